// File: flist.f
+incdir+source
+incdir+test
source/mcs4_pkg.sv
source/instr_fetch.sv
source/index_regs.sv
source/exec_unit.sv
source/mcs4_cpu.sv
test/mcs4_cpu_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module mcs4_cpu_tb -Mdir obj_dir
	./obj_dir/Vmcs4_cpu_tb | tee $(LOG)
	@grep -qx "Finished with no errors" $(LOG) || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: test/mcs4_model.svh
`ifndef MCS4_MODEL_SVH
`define MCS4_MODEL_SVH

// Architectural state as seen on the debug ports
typedef struct packed {
  logic                       carry;
  char_t                      accum;
  char_t [`MCS4_NUM_REGS-1:0] regs;
} model_state_t;

// One single-word instruction applied to the model state
function automatic model_state_t apply_instr(input model_state_t s, input logic [7:0] word);
  model_state_t n;
  logic [3:0]   opr;
  logic [3:0]   opa;
  char_t        r;
  n   = s;
  opr = word[7:4];
  opa = word[3:0];
  r   = s.regs[opa];
  case (opr)
    4'h6: n.regs[opa] = r + 4'd1;
    4'h8: begin
      n.carry = (int'(s.accum) + int'(r)) > 15;
      n.accum = s.accum + r;
    end
    // Borrow whenever the register is the larger operand
    4'h9: begin
      n.carry = s.accum < r;
      n.accum = s.accum - r;
    end
    4'hA: n.accum = r;
    4'hB: begin
      n.accum     = r;
      n.regs[opa] = s.accum;
    end
    4'hD: n.accum = opa;
    4'hF: begin
      case (opa)
        4'h0: n = {1'b0, 4'h0, s.regs};
        4'h1: n.carry = 1'b0;
        4'h2: begin
          n.carry = (s.accum == 4'hF);
          n.accum = s.accum + 4'd1;
        end
        4'h3: n.carry = !s.carry;
        4'h4: n.accum = ~s.accum;
        4'h5: begin
          n.carry = s.accum[3];
          n.accum = {s.accum[2:0], s.carry};
        end
        4'h6: begin
          n.carry = s.accum[0];
          n.accum = {s.carry, s.accum[3:1]};
        end
        4'h7: n = {1'b0, 3'b000, s.carry, s.regs};
        // Decrement borrows only from zero
        4'h8: begin
          n.carry = (s.accum == 4'h0);
          n.accum = s.accum - 4'd1;
        end
        4'hA: n.carry = 1'b1;
        default: ;
      endcase
    end
    default: ;
  endcase
  return n;
endfunction

`endif

// File: test/mcs4_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs4_defs.svh"

module mcs4_cpu_tb;

  import mcs4_pkg::*;

`include "mcs4_model.svh"

  localparam int NUM_TESTS = 5;
  // 299 instructions of 8 cycles plus 16 reset cycles and some margin
  localparam int MAX_CYCLES = 3000;
  localparam logic [3:0] GRP_OPA [10] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 10};
  localparam logic [3:0] KEPT_OPR [8] = '{0, 6, 8, 9, 10, 11, 13, 15};
  localparam logic [3:0] ODD_OPR [8] = '{1, 2, 3, 4, 5, 7, 12, 14};

  logic clk, rst, sync, cm_rom, dbg_carry, all_done, synced;
  char_t dbus_in, dbus_out, dbg_accum;
  addr_t dbg_pc, fetch_addr;
  instr_t dbg_instr;
  char_t [`MCS4_NUM_REGS-1:0] dbg_idx_reg;
  logic [7:0] rom [1 << `MCS4_ADDR_W];
  logic [7:0] words [$];
  string test_name [NUM_TESTS];
  int test_end [NUM_TESTS];
  int prog_len, n_tests, n_done, cur_test, phase, cycles, seed, r;
  int checks, errors, test_checks, test_errors;
  model_state_t model;

  mcs4_cpu mcs4_cpu_i (
    .clk(clk), .rst(rst), .dbus_in(dbus_in), .dbus_out(dbus_out), .sync(sync),
    .cm_rom(cm_rom), .dbg_pc(dbg_pc), .dbg_instr(dbg_instr), .dbg_accum(dbg_accum),
    .dbg_carry(dbg_carry), .dbg_idx_reg(dbg_idx_reg)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      $display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic put_word(input logic [7:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task automatic close_test(input string name);
    test_name[n_tests] = name;
    test_end[n_tests] = prog_len;
    n_tests++;
  endtask

  // Own phase count that restarts at A1 after each sync
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rst || sync) begin
      phase <= 0;
    end else begin
      phase <= phase + 1;
    end
    synced <= !rst && (synced || sync);
  end

  // ========================================
  // ROM model on the bus
  // ========================================
  always @(negedge clk) begin
    check_value("sync", sync, phase == 7);
    check_value("cm_rom", cm_rom, phase == 2);
    if (phase >= 3) check_value("dbus_out", dbus_out, 0);
    if (phase <= 2) fetch_addr[4*phase +: 4] = dbus_out;
    if (phase == 2) begin
      check_value("address on dbus_out", fetch_addr, n_done % 4096);
      check_value("dbg_pc", dbg_pc, n_done % 4096);
    end
    dbus_in = (phase == 3) ? rom[fetch_addr][7:4] : (phase == 4) ? rom[fetch_addr][3:0] : '0;
  end

  // ========================================
  // Comparison in each A1 after a sync
  // ========================================
  always @(negedge clk) begin
    // Runs just after the bus checks of the same edge
    #1;
    if (phase == 0 && synced && !all_done) begin
      model = apply_instr(model, rom[n_done]);
      n_done++;
      check_value("dbg_pc", dbg_pc, n_done % 4096);
      check_value("dbg_instr", dbg_instr, rom[n_done-1]);
      check_value("dbg_accum", dbg_accum, model.accum);
      check_value("dbg_carry", dbg_carry, model.carry);
      for (int k = 0; k < `MCS4_NUM_REGS; k++) begin
        check_value($sformatf("dbg_idx_reg[%0d]", k), dbg_idx_reg[k], model.regs[k]);
      end
      if (n_done == test_end[cur_test]) begin
        $display("Test %0d %s: %0d checks, %0d errors", cur_test + 1, test_name[cur_test],
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
        cur_test++;
        all_done = (cur_test == NUM_TESTS);
      end
    end
  end

  initial begin
    {clk, rst, dbus_in, fetch_addr, model, all_done} = '0;
    rst = 1'b1;
    seed = 36;
    {prog_len, n_tests, n_done, cur_test, cycles} = '0;
    {checks, errors, test_checks, test_errors} = '0;
    // Unused ROM holds NOPs whose OPA depends on the whole address
    for (int a = 0; a < 4096; a++) rom[a] = {4'h0, a[3:0] ^ a[7:4] ^ a[11:8]};
    words = '{8'h00, 8'h00, 8'h00, 8'h00};
    foreach (words[i]) put_word(words[i]);
    close_test("reset and bus timing");
    words = '{8'hD5, 8'hB3, 8'hD9, 8'hB7, 8'hDC, 8'hB0, 8'hA3, 8'hBF, 8'hA7, 8'hB3,
              8'hA0, 8'hD2, 8'hB7, 8'hAF};
    foreach (words[i]) put_word(words[i]);
    close_test("data moves");
    words = '{8'hD9, 8'hB1, 8'hD8, 8'h81, 8'hD3, 8'h81, 8'hD2, 8'h91, 8'hDF, 8'h91, 8'hDF,
              8'hB2, 8'h62, 8'h62, 8'hD0, 8'h91, 8'hD7, 8'h82, 8'h65, 8'hDF, 8'h81};
    foreach (words[i]) put_word(words[i]);
    close_test("arithmetic");
    // Each group op from carry 0 and from carry 1 with IAC and DAC at their edges
    foreach (GRP_OPA[k]) begin
      for (int c = 0; c < 2; c++) begin
        put_word({4'hD, (c == 1 && k == 2) ? 4'hF :
                        (c == 1 && k == 8) ? 4'h0 : 4'(k * 7 + c * 9 + 1)});
        put_word((c == 1) ? 8'hFA : 8'hF1);
        put_word({4'hF, GRP_OPA[k]});
      end
    end
    close_test("accumulator group");
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      if (i % 20 == 10) put_word({ODD_OPR[r[10:8]], r[3:0]});
      else if (KEPT_OPR[r[6:4]] == 4'hF) put_word({4'hF, GRP_OPA[int'(r[15:8]) % 10]});
      else put_word({KEPT_OPR[r[6:4]], r[3:0]});
    end
    close_test("random program");
    repeat (16) @(negedge clk);
    rst = 1'b0;
    while (!all_done && cycles < MAX_CYCLES) @(posedge clk);
    if (!all_done) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions checked",
               cycles, n_done, prog_len);
      errors++;
    end
    $display("%0d of %0d tests run, %0d checks, %0d errors", cur_test, NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/mcs4_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs4_defs.svh"

module mcs4_cpu (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire mcs4_pkg::char_t                 dbus_in,
  output mcs4_pkg::char_t                      dbus_out,
  output logic                                 sync,
  output logic                                 cm_rom,
  output mcs4_pkg::addr_t                      dbg_pc,
  output mcs4_pkg::instr_t                     dbg_instr,
  output mcs4_pkg::char_t                      dbg_accum,
  output logic                                 dbg_carry,
  output mcs4_pkg::char_t [`MCS4_NUM_REGS-1:0] dbg_idx_reg
);

  import mcs4_pkg::*;

  instr_cyc_t icyc;
  instr_t     instr;
  idx_req_t   idx_req;
  char_t      rdata;

  // Timing, program counter and instruction fetch
  instr_fetch instr_fetch_i (
    .clk      (clk),
    .rst      (rst),
    .dbus_in  (dbus_in),
    .icyc     (icyc),
    .instr    (instr),
    .pc       (dbg_pc),
    .dbus_out (dbus_out),
    .sync     (sync),
    .cm_rom   (cm_rom)
  );

  index_regs index_regs_i (
    .clk     (clk),
    .rst     (rst),
    .icyc    (icyc),
    .idx_req (idx_req),
    .rdata   (rdata),
    .regs    (dbg_idx_reg)
  );

  exec_unit exec_unit_i (
    .clk     (clk),
    .rst     (rst),
    .icyc    (icyc),
    .instr   (instr),
    .rdata   (rdata),
    .idx_req (idx_req),
    .accum   (dbg_accum),
    .carry   (dbg_carry)
  );

  assign dbg_instr = instr;

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs4_defs.svh"

module exec_unit (
  input  wire                       clk,
  input  wire                       rst,
  input  wire mcs4_pkg::instr_cyc_t icyc,
  input  wire mcs4_pkg::instr_t     instr,
  input  wire mcs4_pkg::char_t      rdata,
  output mcs4_pkg::idx_req_t        idx_req,
  output mcs4_pkg::char_t           accum,
  output logic                      carry
);

  import mcs4_pkg::*;

  accum_opa_t            acc_op;
  logic [`MCS4_CHAR_W:0] cy_acc;
  logic [`MCS4_CHAR_W:0] cy_acc_next;
  logic                  wen_next;
  char_t                 wdata_next;
  logic                  req_wen;
  char_t                 req_wdata;

  // Carry sits on top of the accumulator for 5-bit arithmetic
  assign cy_acc = {carry, accum};
  assign acc_op = accum_opa_t'(instr.opa);

  // ========================================
  // ALU
  // ========================================
  always_comb begin
    cy_acc_next = cy_acc;
    case (instr.opr)
      ADD: cy_acc_next = {1'b0, accum} + {1'b0, rdata};
      // Carry out is the borrow
      SUB: cy_acc_next = {1'b0, accum} - {1'b0, rdata};
      LD:  cy_acc_next = {carry, rdata};
      XCH: cy_acc_next = {carry, rdata};
      LDM: cy_acc_next = {carry, instr.opa};
      ACCUM_GRP: begin
        case (acc_op)
          CLB: cy_acc_next = '0;
          CLC: cy_acc_next = {1'b0, accum};
          IAC: cy_acc_next = {1'b0, accum} + (`MCS4_CHAR_W+1)'(1);
          CMC: cy_acc_next = {~carry, accum};
          CMA: cy_acc_next = {carry, ~accum};
          RAL: cy_acc_next = {accum, carry};
          RAR: cy_acc_next = {accum[0], carry, accum[`MCS4_CHAR_W-1:1]};
          TCC: cy_acc_next = {1'b0, {(`MCS4_CHAR_W-1){1'b0}}, carry};
          DAC: cy_acc_next = {1'b0, accum} - (`MCS4_CHAR_W+1)'(1);
          STC: cy_acc_next = {1'b1, accum};
          default: ;
        endcase
      end
      // NOP and unknown codes leave everything alone
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
      accum <= '0;
    end else if (icyc == X2) begin
      {carry, accum} <= cy_acc_next;
    end
  end

  // ========================================
  // Index register write request
  // ========================================
  assign wen_next   = (instr.opr == INC) || (instr.opr == XCH);
  // XCH writes back the accumulator before X2 overwrites it
  assign wdata_next = (instr.opr == XCH) ? accum : rdata + char_t'(1);

  // Write enable lives only in X3
  always_ff @(posedge clk) begin
    if (rst) begin
      req_wen <= 1'b0;
    end else if (icyc == X2) begin
      req_wen <= wen_next;
    end else if (icyc == X3) begin
      req_wen <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (icyc == X2) begin
      req_wdata <= wdata_next;
    end
  end

  assign idx_req.wen   = req_wen;
  assign idx_req.addr  = instr.opa;
  assign idx_req.wdata = req_wdata;

  // Accumulator group never touches the register file
  no_grp_write: assert property (
    @(posedge clk) disable iff (rst)
    idx_req.wen |-> (instr.opr != ACCUM_GRP)
  ) else $error("register write requested by accumulator group op");

endmodule

`default_nettype wire

// File: source/index_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs4_defs.svh"

module index_regs (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire mcs4_pkg::instr_cyc_t            icyc,
  input  wire mcs4_pkg::idx_req_t              idx_req,
  output mcs4_pkg::char_t                      rdata,
  output mcs4_pkg::char_t [`MCS4_NUM_REGS-1:0] regs
);

  import mcs4_pkg::*;

  // ========================================
  // Read side
  // ========================================

  // Selected register held for the ALU in X2
  always_ff @(posedge clk) begin
    if (icyc == X1) begin
      rdata <= regs[idx_req.addr];
    end
  end

  // ========================================
  // Write side
  // ========================================

  // Single write slot per instruction, at the end of X3
  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
    end else if (icyc == X3 && idx_req.wen) begin
      regs[idx_req.addr] <= idx_req.wdata;
    end
  end

  // Address comes straight from the instruction register in the fetch unit
  wr_addr_known: assert property (
    @(posedge clk) disable iff (rst)
    (icyc == X3 && idx_req.wen) |-> !$isunknown(idx_req.addr)
  ) else $error("index register write with unknown address");

endmodule

`default_nettype wire

// File: source/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mcs4_defs.svh"

module instr_fetch (
  input  wire                  clk,
  input  wire                  rst,
  input  wire mcs4_pkg::char_t dbus_in,
  output mcs4_pkg::instr_cyc_t icyc,
  output mcs4_pkg::instr_t     instr,
  output mcs4_pkg::addr_t      pc,
  output mcs4_pkg::char_t      dbus_out,
  output logic                 sync,
  output logic                 cm_rom
);

  import mcs4_pkg::*;

  // ========================================
  // Timing generation
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      icyc <= A1;
    end else begin
      // X3 wraps back to A1
      icyc <= icyc.next();
    end
  end

  // Strobes are registered one phase early so they line up with X3 and A3
  always_ff @(posedge clk) begin
    if (rst) begin
      sync   <= 1'b0;
      cm_rom <= 1'b0;
    end else begin
      sync   <= (icyc == X2);
      cm_rom <= (icyc == A2);
    end
  end

  // Program counter, advanced once per instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (icyc == X3) begin
      pc <= pc + addr_t'(1);
    end
  end

  // ========================================
  // Bus access
  // ========================================

  // Address nibbles, low first
  always_comb begin
    case (icyc)
      A1:      dbus_out = pc[0 +: `MCS4_CHAR_W];
      A2:      dbus_out = pc[`MCS4_CHAR_W +: `MCS4_CHAR_W];
      A3:      dbus_out = pc[2*`MCS4_CHAR_W +: `MCS4_CHAR_W];
      default: dbus_out = '0;
    endcase
  end

  // Instruction register, OPR then OPA
  always_ff @(posedge clk) begin
    if (rst) begin
      instr.opr <= NOP;
      instr.opa <= '0;
    end else if (icyc == M1) begin
      instr.opr <= opr_code_t'(dbus_in);
    end else if (icyc == M2) begin
      instr.opa <= dbus_in;
    end
  end

  // Registered sync has to stay in step with the phase counter
  sync_in_x3: assert property (@(posedge clk) disable iff (rst) sync == (icyc == X3))
    else $error("sync not aligned with X3");

endmodule

`default_nettype wire

// File: source/mcs4_pkg.sv
`default_nettype none

`include "mcs4_defs.svh"

package mcs4_pkg;

  // ========================================
  // Vector types
  // ========================================
  typedef logic [`MCS4_CHAR_W-1:0]           char_t;
  typedef logic [`MCS4_ADDR_W-1:0]           addr_t;
  typedef logic [$clog2(`MCS4_NUM_REGS)-1:0] raddr_t;

  // ========================================
  // Encodings
  // ========================================

  // Instruction cycle, A1 right after sync
  typedef enum logic [$clog2(`MCS4_NUM_PHASES)-1:0] {
    A1, A2, A3, M1, M2, X1, X2, X3
  } instr_cyc_t;

  // Upper instruction nibble
  // Codes missing here fall through to NOP behaviour
  typedef enum logic [`MCS4_CHAR_W-1:0] {
    NOP       = 4'h0,
    INC       = 4'h6,
    ADD       = 4'h8,
    SUB       = 4'h9,
    LD        = 4'hA,
    XCH       = 4'hB,
    LDM       = 4'hD,
    ACCUM_GRP = 4'hF
  } opr_code_t;

  // Lower nibble inside the accumulator group
  typedef enum logic [`MCS4_CHAR_W-1:0] {
    CLB = 4'h0,
    CLC = 4'h1,
    IAC = 4'h2,
    CMC = 4'h3,
    CMA = 4'h4,
    RAL = 4'h5,
    RAR = 4'h6,
    TCC = 4'h7,
    DAC = 4'h8,
    STC = 4'hA
  } accum_opa_t;

  // ========================================
  // Bundles
  // ========================================
  typedef struct packed {
    opr_code_t opr;
    char_t     opa;
  } instr_t;

  // Execute unit to register file
  typedef struct packed {
    logic   wen;
    raddr_t addr;
    char_t  wdata;
  } idx_req_t;

endpackage

`default_nettype wire

// File: source/mcs4_defs.svh
`ifndef MCS4_DEFS_SVH
`define MCS4_DEFS_SVH

// ========================================
// MCS-4 core dimensions
// ========================================

// Width of the shared bus and of every data nibble
`define MCS4_CHAR_W 4

// Program address, sent as three bus nibbles
`define MCS4_ADDR_W 12

// Number of index registers
`define MCS4_NUM_REGS 16

// Clock phases in one instruction cycle
`define MCS4_NUM_PHASES 8

`endif
